// File: include/sd_cmd_consts.svh
`ifndef SD_CMD_CONSTS_SVH
`define SD_CMD_CONSTS_SVH

// ========================================
// CMD line frame layout
// ========================================

// Full command or response frame in bits
`define SD_CMD_BITS 48

// CRC7 field length
`define SD_CRC_BITS 7

// Start bit, transmission bit, index and argument
`define SD_PAYLOAD_BITS 40

// ========================================
// Line turnaround
// ========================================

// Cycles after the drive ends with the input forced high
`define SD_TURNAROUND_CYCLES 2

`endif

// File: hw/sd_cmd_pkg.sv
`include "sd_cmd_consts.svh"

package sd_cmd_pkg;

    // One frame as it travels on the CMD line
    typedef logic [`SD_CMD_BITS-1:0] cmd_word_t;

    typedef logic [`SD_CRC_BITS-1:0] crc7_t;

    // Counts bits within one frame
    typedef logic [5:0] bit_count_t;

    typedef enum logic {
        RESP_NONE = 1'b0,
        RESP_48   = 1'b1
    } resp_type_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOAD, ST_SEND, ST_SEND_CRC,
        ST_WAIT_START, ST_RECV, ST_RECV_CRC, ST_FINISH
    } ctrl_state_t;

endpackage

// File: hw/crc7_serial.sv
`timescale 1ns/10ps

`include "sd_cmd_consts.svh"

module crc7_serial (
    input  logic clk_int,
    input  logic rst,
    input  logic crc_rst,
    input  logic crc_en,
    input  logic crc_shift,
    input  logic din,
    output logic crc_bit
);
    import sd_cmd_pkg::*;

    crc7_t crc;
    logic  feedback;

    // Generator x^7 + x^3 + 1
    assign feedback = din ^ crc[`SD_CRC_BITS-1];

    always_ff @(posedge clk_int) begin
        if (rst || crc_rst) begin
            crc <= '0;
        end else if (crc_en) begin
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end else if (crc_shift) begin
            // Present the next CRC bit at the top
            crc <= {crc[`SD_CRC_BITS-2:0], 1'b0};
        end
    end

    assign crc_bit = crc[`SD_CRC_BITS-1];

endmodule

// File: hw/cmd_shifter.sv
`timescale 1ns/10ps

`include "sd_cmd_consts.svh"

module cmd_shifter (
    input  logic                  clk_int,
    input  logic                  rst,
    input  sd_cmd_pkg::cmd_word_t cmd_data,
    input  logic                  shift_load,
    input  logic                  shift_en,
    input  logic                  crc_insert,
    input  logic                  crc_bit,
    input  logic                  in_mask,
    input  logic                  capture,
    input  logic                  sd_cmd_in,
    output logic                  sd_cmd_out,
    output logic                  rx_bit,
    output sd_cmd_pkg::cmd_word_t resp_data
);
    import sd_cmd_pkg::*;

    localparam int tail_bits = `SD_CMD_BITS - `SD_PAYLOAD_BITS;

    cmd_word_t shift_reg;

    // ========================================
    // Frame register
    // ========================================

    // The low byte is replaced by ones so the end bit leaves as 1
    // and the CRC slots are overridden on the way out
    always_ff @(posedge clk_int) begin
        if (shift_load) begin
            shift_reg <= {cmd_data[`SD_CMD_BITS-1:tail_bits], {tail_bits{1'b1}}};
        end else if (shift_en) begin
            shift_reg <= {shift_reg[`SD_CMD_BITS-2:0], rx_bit};
        end
    end

    // Line stays high whenever the controller neither drives nor turns around
    assign sd_cmd_out = !in_mask   ? 1'b1 :
                        crc_insert ? crc_bit :
                                     shift_reg[`SD_CMD_BITS-1];

    // ========================================
    // Input staging and capture
    // ========================================

    always_ff @(posedge clk_int) begin
        if (rst) begin
            rx_bit    <= 1'b1;
            resp_data <= '0;
        end else begin
            // Ignore the line during our own drive and the turnaround
            rx_bit <= in_mask ? 1'b1 : sd_cmd_in;
            if (capture) begin
                resp_data <= shift_reg;
            end
        end
    end

endmodule

// File: hw/cmd_ctrl.sv
`timescale 1ns/10ps

`include "sd_cmd_consts.svh"

module cmd_ctrl (
    input  logic                   clk_int,
    input  logic                   rst,
    input  logic                   cmd_trigger,
    input  sd_cmd_pkg::resp_type_t cmd_resp_type,
    input  logic                   rx_bit,
    input  logic                   cmd_crc_bit,
    input  logic                   resp_crc_bit,
    output logic                   sd_cmd_oe,
    output logic                   shift_load,
    output logic                   shift_en,
    output logic                   crc_insert,
    output logic                   in_mask,
    output logic                   capture,
    output logic                   cmd_crc_rst,
    output logic                   cmd_crc_en,
    output logic                   cmd_crc_shift,
    output logic                   resp_crc_rst,
    output logic                   resp_crc_en,
    output logic                   resp_crc_shift,
    output logic                   cmd_done,
    output logic                   resp_done,
    output logic                   resp_crc_err
);
    import sd_cmd_pkg::*;

    // Counter start values, each state counts down to zero
    localparam bit_count_t payload_last = bit_count_t'(`SD_PAYLOAD_BITS - 1);
    localparam bit_count_t recv_last    = bit_count_t'(`SD_PAYLOAD_BITS - 2);
    localparam bit_count_t tail_last    = bit_count_t'(`SD_CMD_BITS - `SD_PAYLOAD_BITS - 1);
    localparam bit_count_t turn_count   = bit_count_t'(`SD_TURNAROUND_CYCLES);

    ctrl_state_t state;
    bit_count_t  bit_cnt;
    logic        trig_prev;
    logic        trig_change;
    logic        sending;
    logic        tx_crc_phase;
    logic        rx_crc_phase;
    logic        start_seen;
    logic        resp_bit_bad;

    assign trig_change = cmd_trigger != trig_prev;

    // ========================================
    // Decoded strobes
    // ========================================

    assign sending      = (state == ST_SEND) || (state == ST_SEND_CRC);
    assign tx_crc_phase = (state == ST_SEND_CRC) && (bit_cnt != '0);
    assign rx_crc_phase = (state == ST_RECV_CRC) && (bit_cnt != '0);

    // First low bit once the turnaround has run out
    assign start_seen = (state == ST_WAIT_START) && (bit_cnt == '0) && !rx_bit;

    assign sd_cmd_oe  = sending;
    assign shift_load = state == ST_LOAD;
    assign shift_en   = sending || (state == ST_WAIT_START) ||
                        (state == ST_RECV) || (state == ST_RECV_CRC);
    assign crc_insert = tx_crc_phase;
    assign in_mask    = sending || ((state == ST_WAIT_START) && (bit_cnt != '0));
    assign capture    = state == ST_FINISH;

    assign cmd_crc_rst   = state == ST_LOAD;
    assign cmd_crc_en    = state == ST_SEND;
    assign cmd_crc_shift = tx_crc_phase;

    assign resp_crc_rst   = (state == ST_WAIT_START) && !start_seen;
    assign resp_crc_en    = start_seen || (state == ST_RECV);
    assign resp_crc_shift = rx_crc_phase;

    // Seven CRC bits against our own, then the end bit against 1
    assign resp_bit_bad = rx_crc_phase ? (rx_bit != resp_crc_bit) : !rx_bit;

    // ========================================
    // Command and response FSM
    // ========================================

    always_ff @(posedge clk_int) begin
        if (rst) begin
            state        <= ST_IDLE;
            bit_cnt      <= '0;
            trig_prev    <= cmd_trigger;
            cmd_done     <= 1'b0;
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
        end else begin
            trig_prev <= cmd_trigger;

            case (state)
                ST_IDLE: begin
                    bit_cnt <= '0;
                end

                ST_LOAD: begin
                    bit_cnt <= payload_last;
                    state   <= ST_SEND;
                end

                // Start bit through argument
                ST_SEND: begin
                    if (bit_cnt == '0) begin
                        bit_cnt <= tail_last;
                        state   <= ST_SEND_CRC;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end

                // CRC7 then the end bit
                ST_SEND_CRC: begin
                    if (bit_cnt == '0) begin
                        cmd_done <= ~cmd_done;
                        if (cmd_resp_type == RESP_48) begin
                            bit_cnt <= turn_count;
                            state   <= ST_WAIT_START;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end

                // Waits as long as the card takes to answer
                ST_WAIT_START: begin
                    resp_crc_err <= 1'b0;
                    if (bit_cnt != '0) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end else if (start_seen) begin
                        bit_cnt <= recv_last;
                        state   <= ST_RECV;
                    end
                end

                ST_RECV: begin
                    if (bit_cnt == '0) begin
                        bit_cnt <= tail_last;
                        state   <= ST_RECV_CRC;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end

                ST_RECV_CRC: begin
                    if (resp_bit_bad) begin
                        resp_crc_err <= 1'b1;
                    end
                    if (bit_cnt == '0) begin
                        state <= ST_FINISH;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end

                // Frame is complete in the shifter at this point
                ST_FINISH: begin
                    resp_done <= ~resp_done;
                    state     <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // A new trigger abandons whatever is in flight
            if (trig_change) begin
                state <= ST_LOAD;
            end
        end
    end

endmodule

// File: hw/sd_cmd_top.sv
`timescale 1ns/10ps

module sd_cmd_top (
    input  logic                   clk_int,
    input  logic                   rst,
    input  logic                   cmd_trigger,
    input  sd_cmd_pkg::cmd_word_t  cmd_data,
    input  sd_cmd_pkg::resp_type_t cmd_resp_type,
    output logic                   cmd_done,
    output logic                   resp_done,
    output sd_cmd_pkg::cmd_word_t  resp_data,
    output logic                   resp_crc_err,
    output logic                   sd_cmd_out,
    output logic                   sd_cmd_oe,
    input  logic                   sd_cmd_in
);
    // Shifter strobes
    logic shift_load;
    logic shift_en;
    logic crc_insert;
    logic in_mask;
    logic capture;
    logic rx_bit;

    // CRC strobes and results
    logic cmd_crc_rst;
    logic cmd_crc_en;
    logic cmd_crc_shift;
    logic cmd_crc_bit;
    logic resp_crc_rst;
    logic resp_crc_en;
    logic resp_crc_shift;
    logic resp_crc_bit;

    cmd_ctrl u_ctrl (
        .clk_int(clk_int), .rst(rst), .cmd_trigger(cmd_trigger),
        .cmd_resp_type(cmd_resp_type), .rx_bit(rx_bit),
        .cmd_crc_bit(cmd_crc_bit), .resp_crc_bit(resp_crc_bit), .sd_cmd_oe(sd_cmd_oe),
        .shift_load(shift_load), .shift_en(shift_en), .crc_insert(crc_insert),
        .in_mask(in_mask), .capture(capture),
        .cmd_crc_rst(cmd_crc_rst), .cmd_crc_en(cmd_crc_en), .cmd_crc_shift(cmd_crc_shift),
        .resp_crc_rst(resp_crc_rst), .resp_crc_en(resp_crc_en),
        .resp_crc_shift(resp_crc_shift), .cmd_done(cmd_done), .resp_done(resp_done),
        .resp_crc_err(resp_crc_err)
    );

    cmd_shifter u_shifter (
        .clk_int(clk_int), .rst(rst), .cmd_data(cmd_data), .shift_load(shift_load),
        .shift_en(shift_en), .crc_insert(crc_insert), .crc_bit(cmd_crc_bit),
        .in_mask(in_mask), .capture(capture), .sd_cmd_in(sd_cmd_in),
        .sd_cmd_out(sd_cmd_out), .rx_bit(rx_bit), .resp_data(resp_data)
    );

    // Command CRC watches what goes out on the line
    crc7_serial cmd_crc (
        .clk_int(clk_int), .rst(rst), .crc_rst(cmd_crc_rst), .crc_en(cmd_crc_en),
        .crc_shift(cmd_crc_shift), .din(sd_cmd_out), .crc_bit(cmd_crc_bit)
    );

    crc7_serial resp_crc (
        .clk_int(clk_int), .rst(rst), .crc_rst(resp_crc_rst), .crc_en(resp_crc_en),
        .crc_shift(resp_crc_shift), .din(rx_bit), .crc_bit(resp_crc_bit)
    );

endmodule

// File: sim/sd_card_model.sv
`timescale 1ns/10ps

`include "sd_cmd_consts.svh"

module sd_card_model (
    input  logic                             clk_int,
    input  logic                             rst,
    input  int                               cycle,
    input  logic                             sd_cmd_out,
    input  logic                             sd_cmd_oe,
    output logic                             sd_cmd_in,
    input  logic                             resp_en,
    input  int                               resp_delay,
    input  logic [`SD_PAYLOAD_BITS-1:0]      resp_body,
    input  logic [`SD_CRC_BITS-1:0]          resp_crc,
    input  logic                             flip_crc,
    input  logic                             flip_end,
    output sd_cmd_pkg::cmd_word_t            cmd_bits,
    output int                               oe_len,
    output int                               oe_start,
    output int                               oe_end
);
    import sd_cmd_pkg::*;

    cmd_word_t frame;
    cmd_word_t tx_frame;
    logic      oe_prev;
    logic      tx_active;
    int        delay_left;
    int        bits_left;

    // Response frame with the chosen fault applied
    assign frame = {resp_body, resp_crc ^ {6'b0, flip_crc}, !flip_end};

    // Pull-up keeps the line high while the card is silent
    assign sd_cmd_in = (tx_active === 1'b1) ? tx_frame[`SD_CMD_BITS-1] : 1'b1;

    always @(posedge clk_int) begin
        if (rst) begin
            oe_prev    <= 1'b0;
            tx_active  <= 1'b0;
            tx_frame   <= '1;
            delay_left <= 0;
            bits_left  <= 0;
            cmd_bits   <= '0;
            oe_len     <= 0;
            oe_start   <= 0;
            oe_end     <= 0;
        end else begin
            oe_prev <= sd_cmd_oe;

            // ========================================
            // Command sampling
            // ========================================
            if (sd_cmd_oe) begin
                cmd_bits <= {cmd_bits[`SD_CMD_BITS-2:0], sd_cmd_out};
                oe_len   <= oe_prev ? oe_len + 1 : 1;
                if (!oe_prev) begin
                    oe_start <= cycle;
                end
            end else if (oe_prev) begin
                oe_end <= cycle;
                if (resp_en) begin
                    tx_frame   <= frame;
                    delay_left <= resp_delay;
                end
            end

            // ========================================
            // Response drive
            // ========================================
            if (delay_left > 1) begin
                delay_left <= delay_left - 1;
            end else if (delay_left == 1) begin
                delay_left <= 0;
                tx_active  <= 1'b1;
                bits_left  <= `SD_CMD_BITS;
            end else if (tx_active) begin
                tx_frame  <= {tx_frame[`SD_CMD_BITS-2:0], 1'b1};
                bits_left <= bits_left - 1;
                if (bits_left == 1) begin
                    tx_active <= 1'b0;
                end
            end
        end
    end

endmodule

// File: sim/sd_cmd_tb.sv
`timescale 1ns/10ps

`include "sd_cmd_consts.svh"

module sd_cmd_tb;
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_CRC,
        FAULT_END
    } fault_t;

    typedef struct packed {
        cmd_word_t                   cmd;
        resp_type_t                  rtype;
        logic [`SD_PAYLOAD_BITS-1:0] body;
        fault_t                      fault;
    } row_t;

    localparam int row_count  = 7;
    localparam int wait_limit = 200;

    // ========================================
    // Stimulus table
    // ========================================

    // Low command byte is junk that the DUT drops
    row_t rows [row_count] = '{
        '{48'h40_0000_0000_00, RESP_NONE, 40'h00_0000_0000, FAULT_NONE},
        '{48'h48_0000_01AA_5C, RESP_48,   40'h08_0000_01AA, FAULT_NONE},
        '{48'h77_0000_0000_3E, RESP_48,   40'h37_0000_0120, FAULT_CRC},
        '{48'h69_40FF_8000_00, RESP_48,   40'h3F_00FF_8000, FAULT_NONE},
        '{48'h42_0000_0000_A7, RESP_48,   40'h02_1234_5678, FAULT_END},
        '{48'h47_0000_0000_11, RESP_NONE, 40'h00_0000_0000, FAULT_NONE},
        '{48'h4D_1234_0000_FF, RESP_48,   40'h0D_0000_0900, FAULT_NONE}
    };

    logic       clk_int = 1'b0;
    logic       rst;
    logic       cmd_trigger;
    cmd_word_t  cmd_data;
    resp_type_t cmd_resp_type;
    logic       cmd_done;
    logic       resp_done;
    cmd_word_t  resp_data;
    logic       resp_crc_err;
    logic       sd_cmd_out;
    logic       sd_cmd_oe;
    logic       sd_cmd_in;

    // Card model controls and observations
    logic                        resp_en;
    int                          resp_delay;
    logic [`SD_PAYLOAD_BITS-1:0] resp_body;
    logic [`SD_CRC_BITS-1:0]     resp_crc;
    logic                        flip_crc;
    logic                        flip_end;
    cmd_word_t                   cmd_bits;
    int                          oe_len;
    int                          oe_start;
    int                          oe_end;

    int   cycle;
    int   cmd_toggles;
    int   resp_toggles;
    int   cmd_done_cycle;
    logic cmd_done_prev;
    logic resp_done_prev;
    int   resp_expect;
    int   checks;
    int   errors;
    int   timeouts;

    always #2 clk_int = ~clk_int;

    sd_cmd_top UUT (
        .clk_int(clk_int), .rst(rst), .cmd_trigger(cmd_trigger), .cmd_data(cmd_data),
        .cmd_resp_type(cmd_resp_type), .cmd_done(cmd_done), .resp_done(resp_done),
        .resp_data(resp_data), .resp_crc_err(resp_crc_err), .sd_cmd_out(sd_cmd_out),
        .sd_cmd_oe(sd_cmd_oe), .sd_cmd_in(sd_cmd_in)
    );

    sd_card_model card (
        .clk_int(clk_int), .rst(rst), .cycle(cycle), .sd_cmd_out(sd_cmd_out),
        .sd_cmd_oe(sd_cmd_oe), .sd_cmd_in(sd_cmd_in), .resp_en(resp_en),
        .resp_delay(resp_delay), .resp_body(resp_body), .resp_crc(resp_crc),
        .flip_crc(flip_crc), .flip_end(flip_end), .cmd_bits(cmd_bits),
        .oe_len(oe_len), .oe_start(oe_start), .oe_end(oe_end)
    );

    // Edge counter and done toggle tracking
    always @(posedge clk_int) begin
        cycle          <= cycle + 1;
        cmd_done_prev  <= cmd_done;
        resp_done_prev <= resp_done;
        if (rst) begin
            cmd_toggles  <= 0;
            resp_toggles <= 0;
        end else begin
            if (cmd_done != cmd_done_prev) begin
                cmd_toggles    <= cmd_toggles + 1;
                cmd_done_cycle <= cycle;
            end
            if (resp_done != resp_done_prev) begin
                resp_toggles <= resp_toggles + 1;
            end
        end
    end

    // CRC7 with x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_calc(input logic [`SD_PAYLOAD_BITS-1:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = `SD_PAYLOAD_BITS - 1; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_for_toggle(input bit on_resp, input int target, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(posedge clk_int);
            ok = (on_resp ? resp_toggles : cmd_toggles) == target;
        end
        if (!ok) begin
            $display("timeout: %s did not toggle within %0d cycles",
                     on_resp ? "resp_done" : "cmd_done", wait_limit);
            timeouts++;
        end
    endtask

    task automatic apply_row(input int r, output bit ok);
        logic [`SD_PAYLOAD_BITS-1:0] sent;
        cmd_word_t                   expect_cmd;
        cmd_word_t                   expect_resp;
        int                          trig_cycle;
        sent        = rows[r].cmd[`SD_CMD_BITS-1:`SD_CMD_BITS-`SD_PAYLOAD_BITS];
        expect_cmd  = {sent, crc7_calc(sent), 1'b1};
        expect_resp = {rows[r].body, crc7_calc(rows[r].body) ^ {6'b0, rows[r].fault == FAULT_CRC},
                       rows[r].fault != FAULT_END};
        @(posedge clk_int);
        cmd_data      <= rows[r].cmd;
        cmd_resp_type <= rows[r].rtype;
        resp_en       <= rows[r].rtype == RESP_48;
        resp_body     <= rows[r].body;
        resp_crc      <= crc7_calc(rows[r].body);
        flip_crc      <= rows[r].fault == FAULT_CRC;
        flip_end      <= rows[r].fault == FAULT_END;
        resp_delay    <= 4 + int'($urandom % 17);
        cmd_trigger   <= ~cmd_trigger;
        trig_cycle    = cycle;
        wait_for_toggle(1'b0, r + 1, ok);
        if (ok) begin
            check_value("sd_cmd_out bits", 64'(cmd_bits), 64'(expect_cmd));
            check_value("sd_cmd_oe high cycles", 64'(oe_len), 64'(`SD_CMD_BITS));
            // oe rises two edges after the toggle and is first sampled one edge later
            check_value("sd_cmd_oe rise cycle", 64'(oe_start), 64'(trig_cycle + 3));
            check_value("cmd_done cycle", 64'(cmd_done_cycle), 64'(oe_end));
            check_value("resp_done count", 64'(resp_toggles), 64'(resp_expect));
        end
        if (ok && rows[r].rtype == RESP_48) begin
            wait_for_toggle(1'b1, resp_expect + 1, ok);
            if (ok) begin
                resp_expect++;
                check_value("resp_data", 64'(resp_data), 64'(expect_resp));
                check_value("resp_crc_err", 64'(resp_crc_err),
                            64'(rows[r].fault != FAULT_NONE));
                check_value("cmd_done count", 64'(cmd_toggles), 64'(r + 1));
            end
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        bit ok;
        rst           <= 1'b1;
        cmd_trigger   <= 1'b0;
        cmd_data      <= '0;
        cmd_resp_type <= RESP_NONE;
        resp_en       <= 1'b0;
        resp_delay    <= 4;
        resp_body     <= '0;
        resp_crc      <= '0;
        flip_crc      <= 1'b0;
        flip_end      <= 1'b0;
        void'($urandom(32'h83251311));
        repeat (2) @(posedge clk_int);
        rst <= 1'b0;
        @(posedge clk_int);

        // Idle outputs straight out of reset
        check_value("sd_cmd_oe", 64'(sd_cmd_oe), 64'd0);
        check_value("sd_cmd_out", 64'(sd_cmd_out), 64'd1);
        check_value("cmd_done", 64'(cmd_done), 64'd0);
        check_value("resp_done", 64'(resp_done), 64'd0);
        check_value("resp_crc_err", 64'(resp_crc_err), 64'd0);
        check_value("resp_data", 64'(resp_data), 64'd0);

        ok = 1'b1;
        for (int r = 0; r < row_count && ok; r++) begin
            apply_row(r, ok);
        end
        check_value("resp_done count", 64'(resp_toggles), 64'(resp_expect));
        check_value("cmd_done count", 64'(cmd_toggles), 64'(row_count));

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sd_cmd_top.f
+incdir+include
hw/sd_cmd_pkg.sv
hw/crc7_serial.sv
hw/cmd_shifter.sv
hw/cmd_ctrl.sv
hw/sd_cmd_top.sv
sim/sd_card_model.sv
sim/sd_cmd_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SD CMD line testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    -f sd_cmd_top.f --top-module sd_cmd_tb -o sd_cmd_sim

sim_output=$(./obj_dir/sd_cmd_sim)
echo "$sim_output"

# Exit status follows the search for the pass line
grep -qx "STATUS: PASS" <<< "$sim_output"
